//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = dcache_tb
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- common/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Address and line geometry
`define DCACHE_ADDR_BITS      32
`define DCACHE_LINE_BYTES     8
`define DCACHE_OFFSET_BITS    3

// Organization, 8 sets of 4 ways
`define DCACHE_WAYS           4
`define DCACHE_WAY_BITS       2
`define DCACHE_SETS           8
`define DCACHE_SET_BITS       3
`define DCACHE_LINE_TAG_BITS  (`DCACHE_ADDR_BITS - `DCACHE_SET_BITS - `DCACHE_OFFSET_BITS)

// Miss tracking and tag widths, a memory tag of 0 means no tag
`define DCACHE_MSHRS          4
`define DCACHE_MSHR_BITS      2
`define DCACHE_MEM_TAG_BITS   4
`define DCACHE_LQ_TAG_BITS    4

`endif

//--- common/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

    typedef enum logic [1:0] {cmd_none, cmd_load, cmd_store} mem_command_t;
    typedef enum logic [1:0] {size_byte, size_half, size_word, size_double} mem_size_t;

    typedef union packed {
        logic [`DCACHE_LINE_BYTES-1:0][7:0]    bytes;
        logic [`DCACHE_LINE_BYTES/2-1:0][15:0] halves;
        logic [`DCACHE_LINE_BYTES/4-1:0][31:0] words;
        logic [8*`DCACHE_LINE_BYTES-1:0]       dword;
    } mem_block_t;

    typedef logic [`DCACHE_ADDR_BITS-1:0]    addr_t;
    typedef logic [`DCACHE_MEM_TAG_BITS-1:0] mem_tag_t;
    typedef logic [`DCACHE_LQ_TAG_BITS-1:0]  lq_tag_t;
    typedef logic [`DCACHE_WAY_BITS-1:0]     way_t;
    typedef logic [`DCACHE_MSHR_BITS-1:0]    mshr_idx_t;
    typedef logic [`DCACHE_OFFSET_BITS-1:0]  offset_t;
    typedef logic [`DCACHE_SET_BITS-1:0]     set_t;
    typedef logic [`DCACHE_LINE_TAG_BITS-1:0] line_tag_t;

    typedef struct packed {
        line_tag_t tag;
        set_t      set;
        offset_t   offset;
    } line_addr_t;

    typedef struct packed {
        mem_command_t command;
        addr_t        addr;
        mem_size_t    size;
        mem_block_t   store_data;
        lq_tag_t      lq_tag;
    } cache_req_t;

    typedef struct packed {
        logic       valid;
        mem_block_t data;
        lq_tag_t    lq_tag;
    } cache_resp_t;

    typedef struct packed {
        mem_command_t command;
        addr_t        addr;
        mem_size_t    size;
        mem_block_t   data;
    } mem_req_t;

    typedef struct packed {
        mem_tag_t   transaction_tag;
        mem_block_t data;
        mem_tag_t   data_tag;
    } mem_resp_t;

    typedef struct packed {
        logic         valid;
        line_tag_t    tag;
        set_t         set;
        way_t         way;
        offset_t      offset;
        mem_command_t command;
        mem_size_t    size;
        mem_block_t   store_data;
        mem_tag_t     mem_tag;
        lq_tag_t      lq_tag;
    } mshr_entry_t;

    // Tag travels along so a refill also serves as the tag update
    typedef struct packed {
        logic       enable;
        set_t       set;
        way_t       way;
        line_tag_t  tag;
        mem_block_t data;
    } line_write_t;

    // Selected field moved to the low bits, zero-extended
    function automatic mem_block_t extract_by_size(mem_block_t blk, offset_t offset,
                                                   mem_size_t size);
        mem_block_t result;
        result = '0;
        case (size)
            size_byte: result.bytes[0]  = blk.bytes[offset];
            size_half: result.halves[0] = blk.halves[offset[`DCACHE_OFFSET_BITS-1:1]];
            size_word: result.words[0]  = blk.words[offset[`DCACHE_OFFSET_BITS-1:2]];
            default:   result = blk;
        endcase
        return result;
    endfunction

    // Low part of the store data placed into the line
    function automatic mem_block_t merge_by_size(mem_block_t blk, offset_t offset,
                                                 mem_size_t size, mem_block_t data);
        mem_block_t result;
        result = blk;
        case (size)
            size_byte: result.bytes[offset] = data.bytes[0];
            size_half: result.halves[offset[`DCACHE_OFFSET_BITS-1:1]] = data.halves[0];
            size_word: result.words[offset[`DCACHE_OFFSET_BITS-1:2]] = data.words[0];
            default:   result = data;
        endcase
        return result;
    endfunction

endpackage

//--- dcache/access_control.sv
module access_control import dcache_pkg::*; (
    input  cache_req_t   req,
    input  logic         hit,
    input  way_t         hit_way,
    input  mem_block_t   hit_line,
    input  logic         line_pending,
    input  logic         can_allocate,
    input  cache_resp_t  refill_resp,
    output line_addr_t   lookup,
    output mem_command_t lookup_command,
    output logic         accept,
    output logic         miss_alloc,
    output line_write_t  store_write,
    output cache_resp_t  resp
);

    logic present;
    logic hit_ok;
    logic miss_ok;
    logic load_hit;

    assign lookup         = line_addr_t'(req.addr);
    assign lookup_command = req.command;
    assign present        = (req.command != cmd_none);

    // ==============================
    // Acceptance
    // ==============================
    // line_pending also covers a refill arriving this cycle
    assign hit_ok     = present && hit && !line_pending;
    assign miss_ok    = present && !hit && !line_pending && can_allocate;
    assign accept     = hit_ok || miss_ok;
    assign miss_alloc = miss_ok;
    assign load_hit   = hit_ok && (req.command == cmd_load);

    // Store hit rewrites the whole line at the next edge
    always_comb begin
        store_write.enable = hit_ok && (req.command == cmd_store);
        store_write.set    = lookup.set;
        store_write.way    = hit_way;
        store_write.tag    = lookup.tag;
        store_write.data   = merge_by_size(hit_line, lookup.offset, req.size, req.store_data);
    end

    // ==============================
    // Response
    // ==============================
    // Load hit and refill never overlap
    always_comb begin
        if (load_hit) begin
            resp.valid  = 1'b1;
            resp.data   = extract_by_size(hit_line, lookup.offset, req.size);
            resp.lq_tag = req.lq_tag;
        end else begin
            resp = refill_resp;
        end
    end

endmodule

//--- dcache/dcache.sv
module dcache import dcache_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  cache_req_t  req,
    output logic        accept,
    output cache_resp_t resp,
    output mem_req_t    mem_req,
    input  mem_resp_t   mem_resp
);

    line_addr_t   lookup;
    mem_command_t lookup_command;
    logic         hit;
    way_t         hit_way;
    way_t         replace_way;
    mem_block_t   hit_line;
    logic         line_pending;
    logic         can_allocate;
    logic         miss_alloc;
    line_write_t  store_write;
    line_write_t  refill_write;
    line_write_t  fill;
    cache_resp_t  refill_resp;

    access_control u_access_control (
        .req(req), .hit(hit), .hit_way(hit_way), .hit_line(hit_line),
        .line_pending(line_pending), .can_allocate(can_allocate),
        .refill_resp(refill_resp), .lookup(lookup), .lookup_command(lookup_command),
        .accept(accept), .miss_alloc(miss_alloc), .store_write(store_write),
        .resp(resp)
    );

    tag_lru_store u_tag_lru_store (
        .clock(clock), .reset(reset), .lookup(lookup), .lookup_command(lookup_command),
        .accept(accept), .fill(fill), .hit(hit), .hit_way(hit_way),
        .replace_way(replace_way)
    );

    line_data_array u_line_data_array (
        .clock(clock), .reset(reset), .set(lookup.set), .hit_way(hit_way),
        .store_write(store_write), .refill_write(refill_write), .hit_line(hit_line)
    );

    miss_handler u_miss_handler (
        .clock(clock), .reset(reset), .lookup(lookup), .req(req),
        .miss_alloc(miss_alloc), .replace_way(replace_way), .mem_resp(mem_resp),
        .can_allocate(can_allocate), .line_pending(line_pending), .mem_req(mem_req),
        .refill_write(refill_write), .refill_resp(refill_resp), .fill(fill)
    );

endmodule

//--- dcache/line_data_array.sv
`include "dcache_config.svh"

module line_data_array import dcache_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  set_t        set,
    input  way_t        hit_way,
    input  line_write_t store_write,
    input  line_write_t refill_write,
    output mem_block_t  hit_line
);

    mem_block_t  lines [`DCACHE_SETS][`DCACHE_WAYS];
    line_write_t line_write;

    assign hit_line = lines[set][hit_way];

    // Refill wins the single write port
    assign line_write = refill_write.enable ? refill_write : store_write;

    always_ff @(posedge clock) begin
        if (line_write.enable) begin
            lines[line_write.set][line_write.way] <= line_write.data;
        end
    end

    // No request is taken while a refill arrives
    assert property (@(posedge clock) disable iff (reset)
        !(store_write.enable && refill_write.enable));

endmodule

//--- dcache/miss_handler.sv
`include "dcache_config.svh"

module miss_handler import dcache_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  line_addr_t  lookup,
    input  cache_req_t  req,
    input  logic        miss_alloc,
    input  way_t        replace_way,
    input  mem_resp_t   mem_resp,
    output logic        can_allocate,
    output logic        line_pending,
    output mem_req_t    mem_req,
    output line_write_t refill_write,
    output cache_resp_t refill_resp,
    output line_write_t fill
);

    mshr_entry_t              entries [`DCACHE_MSHRS];
    logic [`DCACHE_MSHRS-1:0] free_vec;
    logic [`DCACHE_MSHRS-1:0] match_vec;
    logic [`DCACHE_MSHRS-1:0] refill_hit;
    mshr_idx_t                alloc_idx;
    mshr_idx_t                refill_idx;
    // Entry whose request still waits for its transaction tag
    mshr_idx_t                wait_idx;
    logic                     awaiting_tag;
    logic                     refill_valid;
    mshr_entry_t              refill_entry;
    line_write_t              refill_line;

    // ==============================
    // Entry search
    // ==============================
    // Descending scan, so the lowest free entry wins
    always_comb begin
        alloc_idx  = '0;
        refill_idx = '0;
        for (int i = `DCACHE_MSHRS - 1; i >= 0; i--) begin
            free_vec[i]   = !entries[i].valid;
            match_vec[i]  = entries[i].valid && (entries[i].tag == lookup.tag) &&
                            (entries[i].set == lookup.set);
            refill_hit[i] = entries[i].valid && (mem_resp.data_tag != '0) &&
                            (entries[i].mem_tag == mem_resp.data_tag);
            if (free_vec[i]) alloc_idx = mshr_idx_t'(i);
            if (refill_hit[i]) refill_idx = mshr_idx_t'(i);
        end
    end

    assign can_allocate = (|free_vec) && !awaiting_tag;
    // Any refill cycle also holds off lookups
    assign line_pending = (|match_vec) || (mem_resp.data_tag != '0);

    // Always a full line load
    always_comb begin
        mem_req = '0;
        if (miss_alloc) begin
            mem_req.command = cmd_load;
            mem_req.addr    = {lookup.tag, lookup.set, {`DCACHE_OFFSET_BITS{1'b0}}};
            mem_req.size    = size_double;
        end
    end

    // ==============================
    // Refill
    // ==============================
    assign refill_valid = |refill_hit;
    assign refill_entry = entries[refill_idx];

    always_comb begin
        refill_line.enable = refill_valid;
        refill_line.set    = refill_entry.set;
        refill_line.way    = refill_entry.way;
        refill_line.tag    = refill_entry.tag;
        if (refill_entry.command == cmd_store) begin
            refill_line.data = merge_by_size(mem_resp.data, refill_entry.offset,
                                             refill_entry.size, refill_entry.store_data);
        end else begin
            refill_line.data = mem_resp.data;
        end
    end

    assign refill_write = refill_line;
    assign fill         = refill_line;

    // Load misses answer with the saved size, offset and lq tag
    always_comb begin
        refill_resp.valid  = refill_valid && (refill_entry.command == cmd_load);
        refill_resp.data   = extract_by_size(mem_resp.data, refill_entry.offset,
                                             refill_entry.size);
        refill_resp.lq_tag = refill_entry.lq_tag;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            awaiting_tag <= 1'b0;
            wait_idx     <= '0;
            for (int i = 0; i < `DCACHE_MSHRS; i++) begin
                entries[i] <= '0;
            end
        end else begin
            if (miss_alloc) begin
                entries[alloc_idx] <= '{valid: 1'b1, tag: lookup.tag, set: lookup.set,
                                        way: replace_way, offset: lookup.offset,
                                        command: req.command, size: req.size,
                                        store_data: req.store_data, mem_tag: '0,
                                        lq_tag: req.lq_tag};
                awaiting_tag <= 1'b1;
                wait_idx     <= alloc_idx;
            end
            if (awaiting_tag && (mem_resp.transaction_tag != '0)) begin
                entries[wait_idx].mem_tag <= mem_resp.transaction_tag;
                awaiting_tag              <= 1'b0;
            end
            if (refill_valid) begin
                entries[refill_idx].valid <= 1'b0;
            end
        end
    end

    // Memory hands back a tag on the cycle after each request
    assert property (@(posedge clock) disable iff (reset)
        miss_alloc |=> (mem_resp.transaction_tag != '0));

    assert property (@(posedge clock) disable iff (reset)
        (mem_resp.data_tag != '0) |-> $onehot(refill_hit));

endmodule

//--- dcache/tag_lru_store.sv
`include "dcache_config.svh"

module tag_lru_store import dcache_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  line_addr_t   lookup,
    input  mem_command_t lookup_command,
    input  logic         accept,
    input  line_write_t  fill,
    output logic         hit,
    output way_t         hit_way,
    output way_t         replace_way
);

    line_tag_t              tags     [`DCACHE_SETS][`DCACHE_WAYS];
    logic [`DCACHE_WAYS-1:0] valid    [`DCACHE_SETS];
    // Ways promised to an outstanding miss, kept out of replacement
    logic [`DCACHE_WAYS-1:0] reserved [`DCACHE_SETS];
    // Age 0 is youngest, ages in a set stay a permutation
    way_t                   age      [`DCACHE_SETS][`DCACHE_WAYS];

    logic [`DCACHE_WAYS-1:0] match;
    logic                   free_found;
    way_t                   best_age;
    logic                   touch;
    set_t                   touch_set;
    way_t                   touch_way;

    // ==============================
    // Lookup
    // ==============================
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            match[w] = valid[lookup.set][w] && (tags[lookup.set][w] == lookup.tag);
            if (match[w]) hit_way = way_t'(w);
        end
        hit = (|match) && (lookup_command != cmd_none);
    end

    // Invalid way first, otherwise the oldest unreserved one
    always_comb begin
        replace_way = '0;
        free_found  = 1'b0;
        best_age    = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (!valid[lookup.set][w] && !reserved[lookup.set][w] && !free_found) begin
                replace_way = way_t'(w);
                free_found  = 1'b1;
            end
        end
        if (!free_found) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                if (!reserved[lookup.set][w] && age[lookup.set][w] >= best_age) begin
                    replace_way = way_t'(w);
                    best_age    = age[lookup.set][w];
                end
            end
        end
    end

    // ==============================
    // State update
    // ==============================
    // Hits and fills never share a cycle
    assign touch     = (accept && hit) || fill.enable;
    assign touch_set = fill.enable ? fill.set : lookup.set;
    assign touch_way = fill.enable ? fill.way : hit_way;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                valid[s]    <= '0;
                reserved[s] <= '0;
                for (int w = 0; w < `DCACHE_WAYS; w++) begin
                    age[s][w] <= way_t'(w);
                end
            end
        end else begin
            if (accept && !hit) begin
                reserved[lookup.set][replace_way] <= 1'b1;
            end
            if (fill.enable) begin
                valid[fill.set][fill.way]    <= 1'b1;
                reserved[fill.set][fill.way] <= 1'b0;
            end
            if (touch) begin
                for (int w = 0; w < `DCACHE_WAYS; w++) begin
                    if (way_t'(w) == touch_way) begin
                        age[touch_set][w] <= '0;
                    end else if (age[touch_set][w] < age[touch_set][touch_way]) begin
                        age[touch_set][w] <= age[touch_set][w] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill.enable) begin
            tags[fill.set][fill.way] <= fill.tag;
        end
    end

    // A line lives in at most one way of its set
    assert property (@(posedge clock) disable iff (reset) $onehot0(match));

endmodule

//--- filelist.f
+incdir+common
common/dcache_pkg.sv
dcache/access_control.sv
dcache/tag_lru_store.sv
dcache/line_data_array.sv
dcache/miss_handler.sv
dcache/dcache.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv

//--- verif/dcache_mem_model.sv
`include "dcache_config.svh"

module dcache_mem_model import dcache_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  mem_req_t  mem_req,
    output mem_resp_t mem_resp
);

    localparam int SLOTS = 8;

    logic        slot_valid [SLOTS];
    mem_tag_t    slot_tag   [SLOTS];
    addr_t       slot_addr  [SLOTS];
    logic [3:0]  slot_wait  [SLOTS];
    mem_tag_t    next_tag;
    logic [31:0] r;
    int          seed;
    int          chosen;
    int          free_slot;

    initial seed = 32'hac4c2cf9;

    // Each byte is its own address plus 8'h5a
    function automatic mem_block_t line_at(addr_t line_addr);
        mem_block_t blk;
        for (int i = 0; i < `DCACHE_LINE_BYTES; i++) begin
            blk.bytes[i] = 8'(line_addr + addr_t'(i) + addr_t'(8'h5a));
        end
        return blk;
    endfunction

    // ==============================
    // Tag now, data 2 to 9 cycles later
    // ==============================
    always @(posedge clock or posedge reset) begin
        if (reset) begin
            mem_resp <= '0;
            next_tag <= mem_tag_t'(1);
            for (int i = 0; i < SLOTS; i++) begin
                slot_valid[i] = 1'b0;
            end
        end else begin
            // Lowest ready slot goes first, the rest keep counting down
            chosen = -1;
            for (int i = 0; i < SLOTS; i++) begin
                if (slot_valid[i] && slot_wait[i] == '0 && chosen < 0) begin
                    chosen = i;
                end else if (slot_valid[i] && slot_wait[i] != '0) begin
                    slot_wait[i] = slot_wait[i] - 4'd1;
                end
            end
            if (chosen >= 0) begin
                mem_resp.data      <= line_at(slot_addr[chosen]);
                mem_resp.data_tag  <= slot_tag[chosen];
                slot_valid[chosen] = 1'b0;
            end else begin
                mem_resp.data     <= '0;
                mem_resp.data_tag <= '0;
            end
            mem_resp.transaction_tag <= '0;
            if (mem_req.command == cmd_load) begin
                free_slot = -1;
                for (int i = 0; i < SLOTS; i++) begin
                    if (!slot_valid[i] && free_slot < 0) free_slot = i;
                end
                if (free_slot >= 0) begin
                    r = $random(seed);
                    slot_valid[free_slot] = 1'b1;
                    slot_tag[free_slot]   = next_tag;
                    slot_addr[free_slot]  = mem_req.addr;
                    slot_wait[free_slot]  = {1'b0, r[2:0]};
                end
                mem_resp.transaction_tag <= next_tag;
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
        end
    end

endmodule

//--- verif/dcache_tb.sv
`include "dcache_config.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int PHASE_A_OPS = 600;
    localparam int PHASE_B_OPS = 10;
    // 40 cycles per operation, with slack for reset and draining
    localparam int CYCLE_LIMIT = 40 * (PHASE_A_OPS + PHASE_B_OPS + 8);
    // Tags A B C D A E A C D B in set 5, and which of them miss
    localparam int B_TAGS [PHASE_B_OPS] = '{16, 17, 18, 19, 16, 20, 16, 18, 19, 17};
    localparam logic [PHASE_B_OPS-1:0] B_MISS = 10'b1000101111;

    logic        clock;
    logic        reset;
    cache_req_t  req;
    logic        accept;
    cache_resp_t resp;
    mem_req_t    mem_req;
    mem_resp_t   mem_resp;

    int          seed;
    int          cycles;
    int          checks [1:6];
    int          errors [1:6];
    logic [7:0]  model [2048];
    logic        line_seen [256];
    logic        line_pending [256];
    logic        first_store [256];
    // Load queue tag of the outstanding miss of each line
    logic        miss_load [256];
    lq_tag_t     miss_lq [256];
    int          line_of_tag [16];
    mem_block_t  expect_data [16];
    int          lq_behavior [16];
    logic [15:0] lq_busy;
    lq_tag_t     lq_next;
    int          misses_out;
    int          prev_line;
    logic        miss_prev;
    logic        taken;
    logic        idle_phase;
    logic        phase_b;
    logic        b_expect_miss;
    cache_resp_t want_resp;
    int          resp_behavior;

    dcache DUT (
        .clock(clock), .reset(reset), .req(req), .accept(accept), .resp(resp),
        .mem_req(mem_req), .mem_resp(mem_resp)
    );

    dcache_mem_model u_mem (
        .clock(clock), .reset(reset), .mem_req(mem_req), .mem_resp(mem_resp)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ==============================
    // Compare tasks
    // ==============================
    task automatic note_failure(input int b, input string what);
        errors[b]++;
        $display("Behavior %0d: %s", b, what);
    endtask

    task automatic check_resp(input int b, input cache_resp_t got, input cache_resp_t want);
        checks[b]++;
        if (got.valid !== want.valid) begin
            errors[b]++;
            $display("[FAIL] resp.valid expected %h got %h", want.valid, got.valid);
        end else if (want.valid) begin
            if (got.data !== want.data) begin
                errors[b]++;
                $display("[FAIL] resp.data expected %h got %h", want.data, got.data);
            end
            if (got.lq_tag !== want.lq_tag) begin
                errors[b]++;
                $display("[FAIL] resp.lq_tag expected %h got %h", want.lq_tag, got.lq_tag);
            end
        end
    endtask

    task automatic check_mem_req(input int b, input mem_req_t got, input mem_req_t want);
        checks[b]++;
        if (got.command !== want.command) begin
            errors[b]++;
            $display("[FAIL] mem_req.command expected %h got %h", want.command, got.command);
        end else if (want.command != cmd_none) begin
            if (got.addr !== want.addr || got.size !== want.size) begin
                errors[b]++;
                $display("[FAIL] mem_req.addr/size expected %h/%h got %h/%h",
                         want.addr, want.size, got.addr, got.size);
            end
        end
    endtask

    task automatic check_idle();
        cache_resp_t want_idle;
        mem_req_t    want_mem;
        want_idle = '0;
        want_mem  = '0;
        if (accept) note_failure(6, "accept was high with no request present");
        check_resp(6, resp, want_idle);
        check_mem_req(6, mem_req, want_mem);
    endtask

    // ==============================
    // Reference model
    // ==============================
    task automatic handle_accept();
        int         a;
        int         line;
        int         n;
        int         beh;
        logic       miss;
        mem_req_t   want_mem;
        mem_block_t value;
        a    = int'(req.addr[10:0]);
        line = a / 8;
        n    = 1 << req.size;
        checks[2]++;
        if (line_pending[line]) begin
            note_failure(2, "request accepted while its line still had an outstanding miss");
        end
        if (mem_resp.data_tag != '0) begin
            note_failure(2, "request accepted in the cycle of a refill");
        end
        miss     = phase_b ? b_expect_miss : !line_seen[line];
        want_mem = '0;
        if (miss) begin
            want_mem.command = cmd_load;
            want_mem.addr    = {req.addr[31:3], 3'b000};
            want_mem.size    = size_double;
            line_pending[line] = 1'b1;
            miss_load[line]    = (req.command == cmd_load);
            miss_lq[line]      = req.lq_tag;
            miss_prev = 1'b1;
            prev_line = line;
            misses_out++;
        end
        check_mem_req(phase_b ? 5 : (miss ? 2 : 4), mem_req, want_mem);
        if (!line_seen[line]) first_store[line] = (req.command == cmd_store);
        line_seen[line] = 1'b1;
        if (req.command == cmd_store) begin
            for (int k = 0; k < n; k++) model[a + k] = req.store_data.bytes[k];
        end else begin
            value = '0;
            for (int k = 0; k < n; k++) value.bytes[k] = model[a + k];
            if (phase_b) beh = 5;
            else if (first_store[line]) beh = 3;
            else if (!miss) beh = 4;
            else beh = 1;
            if (miss) begin
                expect_data[req.lq_tag] = value;
                lq_behavior[req.lq_tag] = beh;
                lq_busy[req.lq_tag]     = 1'b1;
            end else begin
                want_resp.valid  = 1'b1;
                want_resp.data   = value;
                want_resp.lq_tag = req.lq_tag;
                resp_behavior    = beh;
            end
        end
    endtask

    // Refill of a load miss answers with the tag saved at acceptance
    task automatic take_refill();
        int      line;
        lq_tag_t tag;
        line = line_of_tag[mem_resp.data_tag];
        line_pending[line] = 1'b0;
        misses_out--;
        if (miss_load[line]) begin
            tag = miss_lq[line];
            want_resp.valid  = 1'b1;
            want_resp.data   = expect_data[tag];
            want_resp.lq_tag = tag;
            resp_behavior    = lq_behavior[tag];
            lq_busy[tag]     = 1'b0;
        end
    endtask

    always @(posedge clock) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end else if (reset || idle_phase) begin
            if (cycles > 1) check_idle();
        end else begin
            if (miss_prev) begin
                line_of_tag[mem_resp.transaction_tag] = prev_line;
                miss_prev = 1'b0;
            end
            want_resp     = '0;
            resp_behavior = 1;
            if (mem_resp.data_tag != '0) take_refill();
            if (accept) begin
                handle_accept();
                taken = 1'b1;
            end
            if (want_resp.valid || resp.valid) check_resp(resp_behavior, resp, want_resp);
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic pick_lq_tag();
        while (lq_busy[lq_next]) lq_next++;
        req.lq_tag = lq_next;
        lq_next++;
    endtask

    task automatic make_random_req();
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] lo;
        r  = $random(seed);
        hi = $random(seed);
        lo = $random(seed);
        req.size       = mem_size_t'(r[1:0]);
        req.addr       = addr_t'(r[9:2]) & ~addr_t'((1 << r[1:0]) - 1);
        req.command    = r[10] ? cmd_store : cmd_load;
        req.store_data = {hi, lo};
        req.lq_tag     = '0;
        if (req.command == cmd_load) pick_lq_tag();
    endtask

    task automatic present_until_accepted();
        taken = 1'b0;
        while (!taken) @(negedge clock);
        req.command = cmd_none;
    endtask

    task automatic wait_for_drain();
        while (misses_out != 0) @(negedge clock);
    endtask

    task automatic report_behavior(input int b, input string what);
        $display("Behavior %0d, %s: %0d checks, %0d errors", b, what, checks[b], errors[b]);
        if (checks[b] == 0) note_failure(b, "no check of this behavior was made");
    endtask

    initial begin
        int total_checks;
        int total_errors;
        seed = 32'hac4c2cf9;
        cycles = 0;
        reset = 1'b1;
        req = '0;
        idle_phase = 1'b0;
        phase_b = 1'b0;
        b_expect_miss = 1'b0;
        miss_prev = 1'b0;
        taken = 1'b0;
        lq_busy = '0;
        lq_next = '0;
        misses_out = 0;
        prev_line = 0;
        want_resp = '0;
        resp_behavior = 1;
        for (int b = 1; b <= 6; b++) begin
            checks[b] = 0;
            errors[b] = 0;
        end
        for (int i = 0; i < 2048; i++) model[i] = 8'(i + 'h5a);
        for (int i = 0; i < 256; i++) begin
            line_seen[i] = 1'b0;
            line_pending[i] = 1'b0;
            first_store[i] = 1'b0;
            miss_load[i] = 1'b0;
            miss_lq[i] = '0;
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        idle_phase = 1'b1;
        repeat (3) @(negedge clock);
        idle_phase = 1'b0;
        report_behavior(6, "idle outputs after reset");

        // Phase A stays inside the 256 byte capacity
        for (int op = 0; op < PHASE_A_OPS; op++) begin
            make_random_req();
            present_until_accepted();
        end
        wait_for_drain();
        report_behavior(1, "random loads and stores");
        report_behavior(2, "miss requests and pending lines");
        report_behavior(3, "store miss merging");
        report_behavior(4, "load hits");

        // Phase B, true LRU in one set
        phase_b = 1'b1;
        for (int i = 0; i < PHASE_B_OPS; i++) begin
            req.command    = cmd_load;
            req.addr       = addr_t'(B_TAGS[i] * 64 + 5 * 8 + 4);
            req.size       = size_word;
            req.store_data = '0;
            pick_lq_tag();
            b_expect_miss = B_MISS[i];
            present_until_accepted();
            wait_for_drain();
        end
        report_behavior(5, "LRU replacement");

        total_checks = 0;
        total_errors = 0;
        for (int b = 1; b <= 6; b++) begin
            total_checks += checks[b];
            total_errors += errors[b];
        end
        $display("Total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
